//--- logic/archPkg.sv
package archPkg;

  // Vector table slot, the vector address is the slot number times 4
  typedef logic [2:0] vectorIndexT;

  // Exception vector slots
  localparam vectorIndexT vecReset         = 3'd0;
  localparam vectorIndexT vecUndefined     = 3'd1;
  localparam vectorIndexT vecSwi           = 3'd2;
  localparam vectorIndexT vecPrefetchAbort = 3'd3;
  localparam vectorIndexT vecDataAbort     = 3'd4;
  // Slot 5 is reserved in the ARM vector table
  localparam vectorIndexT vecIrq           = 3'd6;
  localparam vectorIndexT vecFiq           = 3'd7;

  // Which PC variant is written to the link register
  typedef logic [1:0] pcSelectT;

  // Normal flow, PCD+8
  localparam pcSelectT pcSelNormal = 2'd0;
  // Faulting instruction itself, PCD+0
  localparam pcSelectT pcSelExact  = 2'd1;
  // Instruction after the last completed one, PCD+4
  localparam pcSelectT pcSelNext   = 2'd2;

endpackage

//--- logic/pipeCtrlPkg.sv
package pipeCtrlPkg;

  // Control states of the exception sequencer
  typedef enum logic [2:0] {
    // Normal execution
    stReady,
    // Second cycle of a data abort, PC is saved here
    stDataAbort2,
    // Last good instruction in E, M or W while an interrupt waits
    stIntE,
    stIntM,
    stIntW,
    // Single-cycle exception travelling through M and W
    stExceptionM,
    stExceptionW
  } exceptionStateT;

  // Single-cycle exception flags, one bit per cause
  typedef logic [2:0] excFlagsT;

  // Bit positions inside excFlagsT
  localparam int excSwiBit           = 2;
  localparam int excPrefetchAbortBit = 1;
  localparam int excUndefinedBit     = 0;

endpackage

//--- logic/exceptionControl.sv
`timescale 1ns/1ps

module exceptionControl import pipeCtrlPkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           dataAbort,
  input  logic           undefinedInstrE,
  input  logic           swiE,
  input  logic           prefetchAbortE,
  input  logic           interruptPending,
  input  logic           unstallD,
  input  logic           stallD,
  input  logic           stallE,
  input  logic           stallM,
  input  logic           stallW,
  input  logic           pcWrPendingF,
  output exceptionStateT state,
  output logic           exceptionFlushD,
  output logic           exceptionFlushE,
  output logic           exceptionFlushM,
  output logic           exceptionFlushW,
  output logic           exceptionStallD,
  output logic           interrupting,
  output logic           dataAbortCycle2,
  output logic           exceptionResetMicrop
);

  exceptionStateT nextState;
  // Flush vector, ordered D E M W
  logic [3:0]     flush;
  // Any of the causes caught in E
  logic           anyCauseE;

  assign anyCauseE = undefinedInstrE | swiE | prefetchAbortE;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stReady;
    end else begin
      state <= nextState;
    end
  end

  // Mealy next state and flush logic
  // Priority in stReady is data abort, then E causes, then interrupts
  always_comb begin
    flush     = 4'b0000;
    nextState = state;
    case (state)
      stReady: begin
        if (dataAbort) begin
          // Caught in M, flush everything behind and in front of it
          // D is stalled as well, stall wins over flush there
          flush     = 4'b1111;
          nextState = stDataAbort2;
        end else if (anyCauseE) begin
          // Caught in E, the older instruction in M still completes
          flush     = 4'b1110;
          // CPSR save waits until the exception reaches M
          nextState = stallM ? stReady : stExceptionM;
        end else if (interruptPending) begin
          // Let the last instruction leave D first
          nextState = stallD ? stReady : stIntE;
        end else begin
          nextState = stReady;
        end
      end

      stDataAbort2: begin
        // PC saved this cycle, D gets the vector fetch
        flush     = 4'b1011;
        nextState = stReady;
      end

      stExceptionM: begin
        // Bubble behind the exception
        flush     = 4'b0100;
        nextState = stallW ? stExceptionM : stExceptionW;
      end

      stExceptionW: begin
        flush     = 4'b1000;
        nextState = stallE ? stExceptionW : stReady;
      end

      stIntE: begin
        flush = 4'b0100;
        if (!interruptPending) begin
          // Line dropped, abandon the interrupt
          nextState = stReady;
        end else if (stallE || pcWrPendingF) begin
          // PC writes hold the whole pipe until they retire
          nextState = stIntE;
        end else begin
          nextState = stIntM;
        end
      end

      stIntM: begin
        flush = 4'b0100;
        if (!interruptPending) begin
          nextState = stReady;
        end else begin
          nextState = stallM ? stIntM : stIntW;
        end
      end

      stIntW: begin
        // Grant happens here, next fetch is the vector
        flush = 4'b1000;
        if (interruptPending && stallW) begin
          nextState = stIntW;
        end else begin
          nextState = stReady;
        end
      end

      default: begin
        nextState = stReady;
      end
    endcase
  end

  assign exceptionFlushD = flush[3];
  assign exceptionFlushE = flush[2];
  assign exceptionFlushM = flush[1];
  assign exceptionFlushW = flush[0];

  // Hold D so the return address stays available
  // A completing branch in W releases D in stIntM to let the target in
  assign exceptionStallD = (state == stIntE) ||
                           ((state == stIntM) && !unstallD) ||
                           (state == stExceptionM) ||
                           ((state == stReady) && (dataAbort || anyCauseE));

  assign interrupting         = (state != stReady);
  assign dataAbortCycle2      = (state == stDataAbort2);
  // Abort the running micro-op sequence on a data abort
  assign exceptionResetMicrop = dataAbort;

  // Data abort always returns to stReady after its second cycle
  assert property (@(posedge clk) disable iff (reset)
    (state == stDataAbort2) |=> (state != stDataAbort2));

  // W holds the instruction ahead of the exception and must retire
  assert property (@(posedge clk) disable iff (reset)
    (state == stExceptionM) |-> !exceptionFlushW);

endmodule

//--- logic/exceptionStageRegs.sv
`timescale 1ns/1ps

module exceptionStageRegs import pipeCtrlPkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           stallE,
  input  logic           stallM,
  input  logic           stallW,
  input  logic           pcUpdateW,
  input  excFlagsT       excFlagsE,
  input  exceptionStateT state,
  output excFlagsT       excFlagsW,
  output logic           unstallD
);

  excFlagsT excFlagsM;

  // E to M, an exception already in flight clears the newer one
  always_ff @(posedge clk) begin
    if (reset) begin
      excFlagsM <= '0;
    end else if (!stallM) begin
      if (state != stReady) begin
        excFlagsM <= '0;
      end else begin
        excFlagsM <= excFlagsE;
      end
    end
  end

  // M to W, only passes while the exception sits in M
  always_ff @(posedge clk) begin
    if (reset) begin
      excFlagsW <= '0;
    end else if (!stallW) begin
      if (state != stExceptionM) begin
        excFlagsW <= '0;
      end else begin
        excFlagsW <= excFlagsM;
      end
    end
  end

  // Branch completing in W, lets its target into D during stIntM
  always_ff @(posedge clk) begin
    if (reset) begin
      unstallD <= 1'b0;
    end else if (!stallE) begin
      unstallD <= pcUpdateW;
    end
  end

  // Only one single-cycle exception reaches W at a time
  assert property (@(posedge clk) disable iff (reset) $onehot0(excFlagsW));

endmodule

//--- logic/interruptGate.sv
`timescale 1ns/1ps

module interruptGate import pipeCtrlPkg::*; (
  input  logic           clk,
  input  logic           reset,
  input  logic           irq,
  input  logic           fiq,
  input  logic           irqEnabled,
  input  logic           fiqEnabled,
  input  exceptionStateT state,
  output logic           interruptPending,
  output logic           irqAssert,
  output logic           fiqAssert
);

  logic irqEnSync;
  logic fiqEnSync;
  logic atIntW;

  // Status register changes on the falling edge
  // Move the enables onto the rising edge
  always_ff @(posedge clk) begin
    if (reset) begin
      irqEnSync <= 1'b0;
      fiqEnSync <= 1'b0;
    end else begin
      irqEnSync <= irqEnabled;
      fiqEnSync <= fiqEnabled;
    end
  end

  // Enters or cancels the interrupt sequence
  assign interruptPending = (fiq && fiqEnSync) || (irq && irqEnSync);

  assign atIntW = (state == stIntW);

  // FIQ has priority over IRQ
  assign fiqAssert = atIntW && fiq && fiqEnSync;
  assign irqAssert = atIntW && irq && irqEnSync && !fiqAssert;

  // Grants are exclusive, the vector would be ambiguous otherwise
  assert property (@(posedge clk) disable iff (reset) !(fiqAssert && irqAssert));

endmodule

//--- logic/vectorSelect.sv
`timescale 1ns/1ps

module vectorSelect import archPkg::*, pipeCtrlPkg::*; (
  input  logic        reset,
  input  logic        dataAbortCycle2,
  input  logic        fiqAssert,
  input  logic        irqAssert,
  input  excFlagsT    excFlagsW,
  output vectorIndexT vectorPCnextF,
  output logic        exceptionSavePC,
  output pcSelectT    pcInSelect
);

  logic swiW;
  logic prefetchAbortW;
  logic undefinedW;
  // Any single-cycle exception in W
  logic anyFlagW;

  assign swiW           = excFlagsW[excSwiBit];
  assign prefetchAbortW = excFlagsW[excPrefetchAbortBit];
  assign undefinedW     = excFlagsW[excUndefinedBit];
  assign anyFlagW       = |excFlagsW;

  // Highest priority cause picks the slot
  always_comb begin
    if (reset) begin
      vectorPCnextF = vecReset;
    end else if (dataAbortCycle2) begin
      vectorPCnextF = vecDataAbort;
    end else if (fiqAssert) begin
      vectorPCnextF = vecFiq;
    end else if (irqAssert) begin
      vectorPCnextF = vecIrq;
    end else if (prefetchAbortW) begin
      vectorPCnextF = vecPrefetchAbort;
    end else if (undefinedW) begin
      vectorPCnextF = vecUndefined;
    end else if (swiW) begin
      vectorPCnextF = vecSwi;
    end else begin
      vectorPCnextF = vecReset;
    end
  end

  // Redirect fetch and write the link register on any cause
  assign exceptionSavePC = reset || dataAbortCycle2 || fiqAssert || irqAssert || anyFlagW;

  always_comb begin
    if (fiqAssert || irqAssert) begin
      // Interrupted instruction never ran, return to it
      pcInSelect = pcSelNext;
    end else if (anyFlagW || dataAbortCycle2) begin
      pcInSelect = pcSelExact;
    end else begin
      pcInSelect = pcSelNormal;
    end
  end

endmodule

//--- logic/exceptionUnit.sv
`timescale 1ns/1ps

module exceptionUnit import archPkg::*, pipeCtrlPkg::*; (
  input  logic        clk,
  input  logic        reset,
  // Exception causes from the pipeline
  input  logic        undefinedInstrE,
  input  logic        swiE,
  input  logic        prefetchAbortE,
  input  logic        dataAbort,
  // Interrupt lines and their CPSR enables
  input  logic        irq,
  input  logic        fiq,
  input  logic        irqEnabled,
  input  logic        fiqEnabled,
  // Hazard unit
  input  logic        stallD,
  input  logic        stallE,
  input  logic        stallM,
  input  logic        stallW,
  input  logic        pcWrPendingF,
  input  logic        pcUpdateW,
  // Flags for the CPSR and link register update in W
  output logic        undefinedInstrW,
  output logic        swiW,
  output logic        prefetchAbortW,
  output logic        dataAbortCycle2,
  output logic        irqAssert,
  output logic        fiqAssert,
  output logic        interrupting,
  // Pipeline control
  output logic        exceptionFlushD,
  output logic        exceptionFlushE,
  output logic        exceptionFlushM,
  output logic        exceptionFlushW,
  output logic        exceptionStallD,
  // Fetch redirection
  output vectorIndexT vectorPCnextF,
  output logic        exceptionResetMicrop,
  output logic        exceptionSavePC,
  output pcSelectT    pcInSelect
);

  exceptionStateT state;
  excFlagsT       excFlagsE;
  excFlagsT       excFlagsW;
  logic           interruptPending;
  logic           unstallD;

  // Pack the E causes in flag order
  assign excFlagsE[excSwiBit]           = swiE;
  assign excFlagsE[excPrefetchAbortBit] = prefetchAbortE;
  assign excFlagsE[excUndefinedBit]     = undefinedInstrE;

  exceptionControl ctrl0 (
    .clk(clk), .reset(reset),
    .dataAbort(dataAbort), .undefinedInstrE(undefinedInstrE),
    .swiE(swiE), .prefetchAbortE(prefetchAbortE),
    .interruptPending(interruptPending), .unstallD(unstallD),
    .stallD(stallD), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .pcWrPendingF(pcWrPendingF), .state(state),
    .exceptionFlushD(exceptionFlushD), .exceptionFlushE(exceptionFlushE),
    .exceptionFlushM(exceptionFlushM), .exceptionFlushW(exceptionFlushW),
    .exceptionStallD(exceptionStallD), .interrupting(interrupting),
    .dataAbortCycle2(dataAbortCycle2), .exceptionResetMicrop(exceptionResetMicrop)
  );

  exceptionStageRegs regs0 (
    .clk(clk), .reset(reset),
    .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .pcUpdateW(pcUpdateW), .excFlagsE(excFlagsE), .state(state),
    .excFlagsW(excFlagsW), .unstallD(unstallD)
  );

  interruptGate gate0 (
    .clk(clk), .reset(reset),
    .irq(irq), .fiq(fiq), .irqEnabled(irqEnabled), .fiqEnabled(fiqEnabled),
    .state(state), .interruptPending(interruptPending),
    .irqAssert(irqAssert), .fiqAssert(fiqAssert)
  );

  vectorSelect vsel0 (
    .reset(reset), .dataAbortCycle2(dataAbortCycle2),
    .fiqAssert(fiqAssert), .irqAssert(irqAssert), .excFlagsW(excFlagsW),
    .vectorPCnextF(vectorPCnextF), .exceptionSavePC(exceptionSavePC),
    .pcInSelect(pcInSelect)
  );

  // W flags out to the CPSR logic
  assign swiW            = excFlagsW[excSwiBit];
  assign prefetchAbortW  = excFlagsW[excPrefetchAbortBit];
  assign undefinedInstrW = excFlagsW[excUndefinedBit];

endmodule

//--- test/exceptionModel.svh
`ifndef EXCEPTION_MODEL_SVH
`define EXCEPTION_MODEL_SVH

// Model registers, updated on each rising edge
exceptionStateT mState;
excFlagsT       mFlagsM;
excFlagsT       mFlagsW;
logic           mUnstallD;
logic           mIrqEn;
logic           mFiqEn;

// Expected outputs for the cycle being checked
logic [3:0]     eFlush;
logic           eStallD;
logic           eDa2;
logic           eIrq;
logic           eFiq;
logic           eSave;
vectorIndexT    eVector;
pcSelectT       eSel;

// Combinational part, from the model registers and the applied inputs
function automatic void modelOutputs();
  logic causeE;
  causeE = undefinedInstrE || swiE || prefetchAbortE;
  // Flushes ordered D E M W
  case (mState)
    stReady:      eFlush = dataAbort ? 4'b1111 : (causeE ? 4'b1110 : 4'b0000);
    stDataAbort2: eFlush = 4'b1011;
    stExceptionM, stIntE, stIntM: eFlush = 4'b0100;
    default:      eFlush = 4'b1000;
  endcase
  eStallD = (mState == stIntE) || (mState == stExceptionM) ||
            ((mState == stIntM) && !mUnstallD) ||
            ((mState == stReady) && (dataAbort || causeE));
  eDa2 = (mState == stDataAbort2);
  // FIQ beats IRQ in the grant cycle
  eFiq = (mState == stIntW) && fiq && mFiqEn;
  eIrq = (mState == stIntW) && irq && mIrqEn && !eFiq;
  eSave = reset || eDa2 || eFiq || eIrq || (|mFlagsW);
  // Flags ordered swi, prefetch abort, undefined
  eVector = reset ? vecReset :
            eDa2 ? vecDataAbort :
            eFiq ? vecFiq :
            eIrq ? vecIrq :
            mFlagsW[1] ? vecPrefetchAbort :
            mFlagsW[0] ? vecUndefined :
            mFlagsW[2] ? vecSwi : vecReset;
  eSel = (eFiq || eIrq) ? pcSelNext :
         (eDa2 || (|mFlagsW)) ? pcSelExact : pcSelNormal;
endfunction

// Sequential part, applied on each rising edge
function automatic void modelStep();
  exceptionStateT nextState;
  logic causeE;
  logic pending;
  causeE = undefinedInstrE || swiE || prefetchAbortE;
  pending = (fiq && mFiqEn) || (irq && mIrqEn);
  nextState = mState;
  case (mState)
    stReady: begin
      if (dataAbort) nextState = stDataAbort2;
      else if (causeE) nextState = stallM ? stReady : stExceptionM;
      else if (pending && !stallD) nextState = stIntE;
    end
    stDataAbort2: nextState = stReady;
    stExceptionM: nextState = stallW ? stExceptionM : stExceptionW;
    stExceptionW: nextState = stallE ? stExceptionW : stReady;
    // A dropped line abandons the interrupt
    stIntE: nextState = !pending ? stReady : ((stallE || pcWrPendingF) ? stIntE : stIntM);
    stIntM: nextState = !pending ? stReady : (stallM ? stIntM : stIntW);
    stIntW: nextState = (pending && stallW) ? stIntW : stReady;
    default: nextState = stReady;
  endcase
  // W takes the old M flags before M loads new ones
  if (!stallW) mFlagsW = (mState == stExceptionM) ? mFlagsM : 3'b000;
  if (!stallM) mFlagsM = (mState == stReady) ? {swiE, prefetchAbortE, undefinedInstrE} : 3'b000;
  if (!stallE) mUnstallD = pcUpdateW;
  mIrqEn = irqEnabled;
  mFiqEn = fiqEnabled;
  mState = nextState;
  if (reset) begin
    mState = stReady;
    mFlagsM = 3'b000;
    mFlagsW = 3'b000;
    mUnstallD = 1'b0;
    mIrqEn = 1'b0;
    mFiqEn = 1'b0;
  end
endfunction

`endif

//--- test/exceptionUnitTb.sv
`timescale 1ns/1ps

module exceptionUnitTb import archPkg::*, pipeCtrlPkg::*; ();

  logic clk;
  logic reset;
  // Causes and interrupt lines
  logic dataAbort, undefinedInstrE, swiE, prefetchAbortE;
  logic irq, fiq, irqEnabled, fiqEnabled;
  // Hazard unit inputs
  logic stallD, stallE, stallM, stallW, pcWrPendingF, pcUpdateW;
  logic undefinedInstrW, swiW, prefetchAbortW, dataAbortCycle2;
  logic irqAssert, fiqAssert, interrupting, exceptionStallD;
  logic exceptionFlushD, exceptionFlushE, exceptionFlushM, exceptionFlushW;
  logic exceptionResetMicrop, exceptionSavePC;
  vectorIndexT vectorPCnextF;
  pcSelectT pcInSelect;
  logic [3:0] flushes;
  excFlagsT flagsW;
  int errors;
  int checks;
  int cycles;

  assign flushes = {exceptionFlushD, exceptionFlushE, exceptionFlushM, exceptionFlushW};
  assign flagsW = {swiW, prefetchAbortW, undefinedInstrW};

  exceptionUnit dut0 (.*);

  `include "exceptionModel.svh"

  // First edge is falling
  initial begin
    clk = 1'b1;
    forever #2 clk = ~clk;
  end

  task automatic checkValue(string name, int got, int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compareModel();
    modelOutputs();
    checkValue("exceptionSavePC", int'(exceptionSavePC), int'(eSave));
    checkValue("vectorPCnextF", int'(vectorPCnextF), int'(eVector));
    // Control state is unknown until the first reset edge
    if (!reset) begin
      checkValue("flushes", int'(flushes), int'(eFlush));
      checkValue("exceptionStallD", int'(exceptionStallD), int'(eStallD));
      checkValue("interrupting", int'(interrupting), int'(mState != stReady));
      checkValue("dataAbortCycle2", int'(dataAbortCycle2), int'(eDa2));
      checkValue("exceptionResetMicrop", int'(exceptionResetMicrop), int'(dataAbort));
      checkValue("fiqAssert", int'(fiqAssert), int'(eFiq));
      checkValue("irqAssert", int'(irqAssert), int'(eIrq));
      checkValue("W flags", int'(flagsW), int'(mFlagsW));
      checkValue("pcInSelect", int'(pcInSelect), int'(eSel));
    end
  endtask

  // Outputs are stable 1 ns after the falling edge
  task automatic settle();
    #1;
    compareModel();
  endtask

  // Rising edge moves the model and the task returns on the falling edge
  task automatic advance();
    @(posedge clk);
    modelStep();
    @(negedge clk);
  endtask

  task automatic step();
    settle();
    advance();
  endtask

  task automatic setIdle();
    {dataAbort, undefinedInstrE, swiE, prefetchAbortE} = '0;
    {irq, fiq, irqEnabled, fiqEnabled} = '0;
    {stallD, stallE, stallM, stallW, pcWrPendingF, pcUpdateW} = '0;
  endtask

  // Quiet inputs until the sequencer is back in stReady
  task automatic waitReady();
    int n;
    n = 0;
    setIdle();
    settle();
    while (interrupting && n < 20) begin
      advance();
      settle();
      n++;
    end
    if (interrupting) begin
      errors++;
      $display("Timeout: the unit did not return to its ready state");
    end
    advance();
  endtask

  // Cycles from the current cycle to the interrupt grant
  task automatic waitGrant();
    cycles = 0;
    settle();
    while (!(fiqAssert || irqAssert) && cycles < 20) begin
      advance();
      settle();
      cycles++;
    end
    if (!(fiqAssert || irqAssert)) begin
      errors++;
      $display("Timeout: no interrupt grant after %0d cycles", cycles);
    end
  endtask

  // Sparse causes with one E cause at a time
  // Lines and enables drift slowly
  task automatic randomInputs();
    int pick;
    pick = $urandom_range(29, 0);
    dataAbort = ($urandom_range(39, 0) == 0);
    undefinedInstrE = (pick == 0);
    prefetchAbortE = (pick == 1);
    swiE = (pick == 2);
    if ($urandom_range(7, 0) == 0) irq = !irq;
    if ($urandom_range(7, 0) == 0) fiq = !fiq;
    if ($urandom_range(15, 0) == 0) irqEnabled = !irqEnabled;
    if ($urandom_range(15, 0) == 0) fiqEnabled = !fiqEnabled;
    stallD = ($urandom_range(4, 0) == 0);
    stallE = ($urandom_range(4, 0) == 0);
    stallM = ($urandom_range(4, 0) == 0);
    stallW = ($urandom_range(4, 0) == 0);
    pcWrPendingF = ($urandom_range(5, 0) == 0);
    pcUpdateW = ($urandom_range(3, 0) == 0);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    void'($urandom(77358));
    reset = 1'b1;
    setIdle();
    @(negedge clk);
    repeat (2) begin
      settle();
      checkValue("save strobe in reset", int'(exceptionSavePC), 1);
      checkValue("vector in reset", int'(vectorPCnextF), int'(vecReset));
      advance();
    end
    reset = 1'b0;
    settle();
    checkValue("control outputs after reset", int'({flushes, exceptionStallD,
      interrupting, irqAssert, fiqAssert, dataAbortCycle2}), 0);
    advance();

    // Plain data abort and then a data abort beating a SWI in the same cycle
    for (int a = 0; a < 2; a++) begin
      waitReady();
      dataAbort = 1'b1;
      swiE = (a == 1);
      settle();
      checkValue("data abort flushes", int'(flushes), int'(4'b1111));
      checkValue("data abort stallD", int'(exceptionStallD), 1);
      checkValue("data abort micro-op reset", int'(exceptionResetMicrop), 1);
      advance();
      setIdle();
      settle();
      checkValue("dataAbortCycle2", int'(dataAbortCycle2), 1);
      checkValue("abort cycle 2 flushes", int'(flushes), int'(4'b1011));
      checkValue("abort vector", int'(vectorPCnextF), int'(vecDataAbort));
      checkValue("abort pcInSelect", int'(pcInSelect), int'(pcSelExact));
      advance();
      settle();
      checkValue("ready after abort", int'({interrupting, flagsW}), 0);
      advance();
    end

    // Undefined, prefetch abort and SWI in E
    for (int c = 0; c < 3; c++) begin
      waitReady();
      {swiE, prefetchAbortE, undefinedInstrE} = 3'b001 << c;
      settle();
      checkValue("E exception flushes", int'(flushes), int'(4'b1110));
      checkValue("E exception stallD", int'(exceptionStallD), 1);
      advance();
      {swiE, prefetchAbortE, undefinedInstrE} = 3'b000;
      settle();
      checkValue("exception in M flushes", int'(flushes), int'(4'b0100));
      checkValue("exception in M stallD", int'(exceptionStallD), 1);
      advance();
      settle();
      checkValue("W flag", int'(flagsW), int'(3'b001 << c));
      checkValue("exception in W flushes", int'(flushes), int'(4'b1000));
      checkValue("exception vector", int'(vectorPCnextF), (c == 0) ? int'(vecUndefined) :
        ((c == 1) ? int'(vecPrefetchAbort) : int'(vecSwi)));
      checkValue("exception pcInSelect", int'(pcInSelect), int'(pcSelExact));
      advance();
      settle();
      checkValue("ready after exception", int'(interrupting), 0);
      advance();
    end

    // FIQ and IRQ together
    waitReady();
    {irqEnabled, fiqEnabled} = 2'b11;
    step();
    {irq, fiq} = 2'b11;
    waitGrant();
    checkValue("FIQ grant latency", cycles, 3);
    checkValue("FIQ wins", int'({fiqAssert, irqAssert}), 2);
    checkValue("FIQ vector", int'(vectorPCnextF), int'(vecFiq));
    checkValue("FIQ pcInSelect", int'(pcInSelect), int'(pcSelNext));
    advance();

    // Enable rising with the line costs one extra cycle
    waitReady();
    {irq, irqEnabled} = 2'b11;
    waitGrant();
    checkValue("IRQ grant latency with new enable", cycles, 4);
    checkValue("IRQ grant", int'(irqAssert), 1);
    checkValue("IRQ vector", int'(vectorPCnextF), int'(vecIrq));
    advance();

    // Line dropped while in stIntM
    waitReady();
    irqEnabled = 1'b1;
    step();
    irq = 1'b1;
    step();
    step();
    irq = 1'b0;
    settle();
    checkValue("busy before cancel", int'(interrupting), 1);
    advance();
    repeat (4) begin
      settle();
      checkValue("no grant after cancel", int'({irqAssert, interrupting}), 0);
      advance();
    end

    setIdle();
    for (int i = 0; i < 3000; i++) begin
      randomInputs();
      step();
    end

    $display("Errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+test
logic/archPkg.sv
logic/pipeCtrlPkg.sv
logic/exceptionControl.sv
logic/exceptionStageRegs.sv
logic/interruptGate.sv
logic/vectorSelect.sv
logic/exceptionUnit.sv
test/exceptionUnitTb.sv

//--- Makefile
TOP = exceptionUnitTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

obj_dir/V$(TOP): list.f logic/*.sv test/*.sv test/*.svh
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
